//--- mem_subsys.f
+incdir+sim
rtl/mem_pkg.sv
rtl/store_format.sv
rtl/load_extend.sv
rtl/mem_stage.sv
rtl/data_ram.sv
rtl/wb_stage.sv
rtl/mem_top.sv
sim/tb_mem_top.sv

//--- Makefile
# Verilator build and run for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_top
FILELIST  ?= mem_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) sim/tb_mem_vectors.svh

.PHONY: all run check clean

all: check

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@grep -q '^\*\* PASS \*\*$$' $(LOG) && echo "simulation passed" || \
	  (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_mem_vectors.svh
// columns: name, op, addr, wdata, csr data, rd, wb_sel, expected rf value, expected mask
task automatic load_vectors();
  // stores of each size, then merged readback
  add_vec("sd_base", mem_pkg::op_sd, 64'h100, 64'h0123_4567_89ab_cdef, 64'h0, 5'd0,
          mem_pkg::wb_ex, 64'h0, 8'hff);
  add_vec("ld_base", mem_pkg::op_ld, 64'h100, 64'h0, 64'h0, 5'd10,
          mem_pkg::wb_load, 64'h0123_4567_89ab_cdef, 8'hff);
  add_vec("sb_off3", mem_pkg::op_sb, 64'h103, 64'hffff_ffff_ffff_ff80, 64'h0, 5'd0,
          mem_pkg::wb_ex, 64'h0, 8'h08);
  add_vec("sh_off6", mem_pkg::op_sh, 64'h106, 64'h1234_8001, 64'h0, 5'd0,
          mem_pkg::wb_ex, 64'h0, 8'hc0);
  add_vec("sw_off0", mem_pkg::op_sw, 64'h108, 64'hdead_beef_f00d_cafe, 64'h0, 5'd0,
          mem_pkg::wb_ex, 64'h0, 8'h0f);
  add_vec("sw_off4", mem_pkg::op_sw, 64'h10c, 64'h8765_4321, 64'h0, 5'd0,
          mem_pkg::wb_ex, 64'h0, 8'hf0);
  add_vec("ld_merge0", mem_pkg::op_ld, 64'h100, 64'h0, 64'h0, 5'd11,
          mem_pkg::wb_load, 64'h8001_4567_80ab_cdef, 8'hff);
  add_vec("ld_merge1", mem_pkg::op_ld, 64'h108, 64'h0, 64'h0, 5'd12,
          mem_pkg::wb_load, 64'h8765_4321_f00d_cafe, 8'hff);
  // signed and unsigned narrow loads
  add_vec("lb_neg", mem_pkg::op_lb, 64'h103, 64'h0, 64'h0, 5'd13,
          mem_pkg::wb_load, 64'hffff_ffff_ffff_ff80, 8'h08);
  add_vec("lbu_neg", mem_pkg::op_lbu, 64'h103, 64'h0, 64'h0, 5'd14,
          mem_pkg::wb_load, 64'h80, 8'h08);
  add_vec("lh_neg", mem_pkg::op_lh, 64'h106, 64'h0, 64'h0, 5'd15,
          mem_pkg::wb_load, 64'hffff_ffff_ffff_8001, 8'hc0);
  add_vec("lhu_neg", mem_pkg::op_lhu, 64'h106, 64'h0, 64'h0, 5'd16,
          mem_pkg::wb_load, 64'h8001, 8'hc0);
  add_vec("lw_neg", mem_pkg::op_lw, 64'h10c, 64'h0, 64'h0, 5'd17,
          mem_pkg::wb_load, 64'hffff_ffff_8765_4321, 8'hf0);
  add_vec("lwu_neg", mem_pkg::op_lwu, 64'h10c, 64'h0, 64'h0, 5'd18,
          mem_pkg::wb_load, 64'h8765_4321, 8'hf0);
  add_vec("lw_off0", mem_pkg::op_lw, 64'h108, 64'h0, 64'h0, 5'd19,
          mem_pkg::wb_load, 64'hffff_ffff_f00d_cafe, 8'h0f);
  add_vec("lb_pos", mem_pkg::op_lb, 64'h104, 64'h0, 64'h0, 5'd20,
          mem_pkg::wb_load, 64'h67, 8'h10);
  add_vec("sh_off2", mem_pkg::op_sh, 64'h112, 64'habcd_ffff, 64'h0, 5'd0,
          mem_pkg::wb_ex, 64'h0, 8'h0c);
  add_vec("sb_off7", mem_pkg::op_sb, 64'h117, 64'h7f, 64'h0, 5'd0,
          mem_pkg::wb_ex, 64'h0, 8'h80);
  add_vec("ld_merge2", mem_pkg::op_ld, 64'h110, 64'h0, 64'h0, 5'd21,
          mem_pkg::wb_load, 64'h7f00_0000_ffff_0000, 8'hff);
  add_vec("lh_off2", mem_pkg::op_lh, 64'h112, 64'h0, 64'h0, 5'd22,
          mem_pkg::wb_load, 64'hffff_ffff_ffff_ffff, 8'h0c);
  // non-memory items
  add_vec("alu_ex", mem_pkg::op_none, 64'h1234_5678_9abc_def0, 64'h0, 64'h0, 5'd5,
          mem_pkg::wb_ex, 64'h1234_5678_9abc_def0, 8'h00);
  add_vec("csr_rd", mem_pkg::op_none, 64'h40, 64'h0, 64'h1800, 5'd7,
          mem_pkg::wb_csr, 64'h1800, 8'h00);
  add_vec("rd_zero", mem_pkg::op_none, 64'h55, 64'h0, 64'h0, 5'd0,
          mem_pkg::wb_ex, 64'h0, 8'h00);
endtask

//--- sim/tb_mem_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_top;

  localparam int ram_wait   = 2;
  localparam int reset_cyc  = 16;
  localparam int rand_items = 24;

  logic                     clk;
  logic                     rst;
  logic                     ex_valid;
  logic [mem_pkg::xlen-1:0] ex_pc;
  mem_pkg::mem_op_e         ex_op;
  logic [mem_pkg::xlen-1:0] ex_addr;
  logic [mem_pkg::xlen-1:0] ex_wdata;
  logic [mem_pkg::xlen-1:0] ex_csr_data;
  logic [4:0]               ex_rd;
  logic                     ex_rd_wen;
  mem_pkg::wb_sel_e         ex_wb_sel;
  logic                     ex_allowin;
  logic [4:0]               fwd_rd;
  logic                     fwd_wen;
  logic [mem_pkg::xlen-1:0] fwd_data;
  mem_pkg::wb_sel_e         fwd_wb_sel;
  logic                     rf_wen;
  logic [4:0]               rf_waddr;
  logic [mem_pkg::xlen-1:0] rf_wdata;
  logic                     commit_valid;
  logic [mem_pkg::xlen-1:0] commit_pc;
  logic                     commit_load;
  logic                     commit_store;
  logic [mem_pkg::xlen-1:0] commit_addr;
  logic [mem_pkg::xlen-1:0] commit_data;
  logic [7:0]               commit_mask;

  string            v_name[$];
  mem_pkg::mem_op_e v_op[$];
  logic [63:0]      v_addr[$];
  logic [63:0]      v_wdata[$];
  logic [63:0]      v_csr[$];
  logic [4:0]       v_rd[$];
  mem_pkg::wb_sel_e v_sel[$];
  logic [63:0]      v_exp_rf[$];
  logic [7:0]       v_mask[$];

  // byte image of the data memory
  logic [7:0]  model_mem [2048];
  logic [63:0] exp_pc_q[$];
  logic [63:0] exp_val_q[$];
  logic [63:0] obs_pc_q[$];
  logic [63:0] obs_val_q[$];

  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  int          limit = 0;
  logic        rand_phase = 1'b0;

  mem_top #(
    .ram_addr_bits (8),
    .ram_wait      (ram_wait)
  ) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  initial begin
    @(posedge clk);
    while (limit == 0 || cycles < limit) begin
      @(posedge clk);
    end
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("** FAIL **");
    $finish;
  end

  // commits seen during the back to back pass, in arrival order
  always @(negedge clk) begin
    if (rand_phase && commit_valid) begin
      obs_pc_q.push_back(commit_pc);
      obs_val_q.push_back(commit_load ? rf_wdata : commit_data);
    end
  end

  task automatic add_vec(input string name, input mem_pkg::mem_op_e op,
                         input logic [63:0] addr, input logic [63:0] wdata,
                         input logic [63:0] csr, input logic [4:0] rd,
                         input mem_pkg::wb_sel_e sel, input logic [63:0] exp_rf,
                         input logic [7:0] mask);
    v_name.push_back(name);
    v_op.push_back(op);
    v_addr.push_back(addr);
    v_wdata.push_back(wdata);
    v_csr.push_back(csr);
    v_rd.push_back(rd);
    v_sel.push_back(sel);
    v_exp_rf.push_back(exp_rf);
    v_mask.push_back(mask);
  endtask

  `include "tb_mem_vectors.svh"

  function automatic logic is_store_op(input mem_pkg::mem_op_e op);
    return op == mem_pkg::op_sb || op == mem_pkg::op_sh || op == mem_pkg::op_sw ||
           op == mem_pkg::op_sd;
  endfunction

  function automatic int op_bytes(input mem_pkg::mem_op_e op);
    case (op)
      mem_pkg::op_lb, mem_pkg::op_lbu, mem_pkg::op_sb: return 1;
      mem_pkg::op_lh, mem_pkg::op_lhu, mem_pkg::op_sh: return 2;
      mem_pkg::op_lw, mem_pkg::op_lwu, mem_pkg::op_sw: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic logic [63:0] model_load(input mem_pkg::mem_op_e op,
                                             input logic [63:0] addr);
    logic [63:0] raw;
    int          nb;
    raw = '0;
    nb = op_bytes(op);
    for (int b = 0; b < nb; b++) begin
      raw[b*8 +: 8] = model_mem[addr[10:0] + 11'(b)];
    end
    case (op)
      mem_pkg::op_lb: if (raw[7]) raw[63:8] = '1;
      mem_pkg::op_lh: if (raw[15]) raw[63:16] = '1;
      mem_pkg::op_lw: if (raw[31]) raw[63:32] = '1;
      default: ;
    endcase
    return raw;
  endfunction

  task automatic model_store(input mem_pkg::mem_op_e op, input logic [63:0] addr,
                             input logic [63:0] wdata);
    int nb;
    nb = op_bytes(op);
    for (int b = 0; b < nb; b++) begin
      model_mem[addr[10:0] + 11'(b)] = wdata[b*8 +: 8];
    end
  endtask

  // store bytes placed in their doubleword lanes
  function automatic logic [63:0] lanes_of(input mem_pkg::mem_op_e op,
                                           input logic [63:0] addr,
                                           input logic [63:0] wdata);
    logic [63:0] d;
    int          nb;
    d = '0;
    nb = op_bytes(op);
    if (is_store_op(op)) begin
      for (int b = 0; b < nb; b++) begin
        d[(int'(addr[2:0]) + b)*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return d;
  endfunction

  task automatic report_mismatch(input string test, input string field,
                                 input logic [63:0] exp, input logic [63:0] act);
    $display("[ERROR] %s %s: expected %h, actual %h", test, field, exp, act);
    errors++;
  endtask

  task automatic report_problem(input string test, input string what);
    $display("%s: %s", test, what);
    errors++;
  endtask

  task automatic finish_test(input string test, input int errs_before);
    if (errors == errs_before) begin
      tests_passed++;
      $display("test %s passed", test);
    end else begin
      tests_failed++;
      $display("test %s failed", test);
    end
  endtask

  task automatic drive_item(input logic [63:0] pc, input mem_pkg::mem_op_e op,
                            input logic [63:0] addr, input logic [63:0] wdata,
                            input logic [63:0] csr, input logic [4:0] rd,
                            input mem_pkg::wb_sel_e sel);
    ex_valid    <= 1'b1;
    ex_pc       <= pc;
    ex_op       <= op;
    ex_addr     <= addr;
    ex_wdata    <= wdata;
    ex_csr_data <= csr;
    ex_rd       <= rd;
    ex_rd_wen   <= !is_store_op(op);
    ex_wb_sel   <= sel;
  endtask

  // returns on the accept edge
  task automatic wait_accept();
    logic ok;
    do begin
      @(negedge clk);
      ok = ex_allowin;
      @(posedge clk);
    end while (!ok);
  endtask

  task automatic run_vector(input int i);
    logic        is_mem;
    logic        is_st;
    logic        expect_evt;
    logic        seen;
    int          lat_exp;
    int          n;
    int          errs_before;
    logic [63:0] model_val;
    logic [63:0] lanes;
    is_mem = v_op[i] != mem_pkg::op_none;
    is_st = is_store_op(v_op[i]);
    expect_evt = is_mem || v_rd[i] != 5'd0;
    lat_exp = is_mem ? ram_wait + 3 : 2;
    errs_before = errors;
    lanes = lanes_of(v_op[i], v_addr[i], v_wdata[i]);
    if (is_mem && !is_st) begin
      model_val = model_load(v_op[i], v_addr[i]);
      if (model_val !== v_exp_rf[i]) begin
        report_mismatch(v_name[i], "table vs model", model_val, v_exp_rf[i]);
      end
    end
    if (is_st) begin
      model_store(v_op[i], v_addr[i], v_wdata[i]);
    end
    @(posedge clk);
    drive_item(64'h8000_0000 + 64'(i * 4), v_op[i], v_addr[i], v_wdata[i], v_csr[i],
               v_rd[i], v_sel[i]);
    wait_accept();
    ex_valid <= 1'b0;
    n = 0;
    seen = 1'b0;
    while (!seen && n < lat_exp + 4) begin
      @(negedge clk);
      n++;
      if (n == 1) begin
        if (is_mem && ex_allowin !== 1'b0) begin
          report_problem(v_name[i], "ex_allowin stayed high while the access waited");
        end
        if (fwd_rd !== v_rd[i]) begin
          report_mismatch(v_name[i], "fwd_rd", 64'(v_rd[i]), 64'(fwd_rd));
        end
        if (fwd_wen !== !is_st) begin
          report_mismatch(v_name[i], "fwd_wen", 64'(!is_st), 64'(fwd_wen));
        end
        if (fwd_data !== v_addr[i]) begin
          report_mismatch(v_name[i], "fwd_data", v_addr[i], fwd_data);
        end
        if (fwd_wb_sel !== v_sel[i]) begin
          report_mismatch(v_name[i], "fwd_wb_sel", 64'(v_sel[i]), 64'(fwd_wb_sel));
        end
      end
      seen = rf_wen || commit_valid;
    end
    if (!expect_evt) begin
      if (seen) begin
        report_problem(v_name[i], "rf_wen rose for a write to x0");
      end
    end else if (!seen) begin
      report_problem(v_name[i], "no register write or commit arrived");
    end else begin
      if (n != lat_exp) begin
        report_mismatch(v_name[i], "latency", 64'(lat_exp), 64'(n));
      end
      if (!is_st) begin
        if (rf_waddr !== v_rd[i]) begin
          report_mismatch(v_name[i], "rf_waddr", 64'(v_rd[i]), 64'(rf_waddr));
        end
        if (rf_wdata !== v_exp_rf[i]) begin
          report_mismatch(v_name[i], "rf_wdata", v_exp_rf[i], rf_wdata);
        end
      end
      if (is_mem) begin
        if (commit_store !== is_st) begin
          report_mismatch(v_name[i], "commit_store", 64'(is_st), 64'(commit_store));
        end
        if (commit_load !== !is_st) begin
          report_mismatch(v_name[i], "commit_load", 64'(!is_st), 64'(commit_load));
        end
        if (commit_addr !== (v_addr[i] & ~64'h7)) begin
          report_mismatch(v_name[i], "commit_addr", v_addr[i] & ~64'h7, commit_addr);
        end
        if (commit_mask !== v_mask[i]) begin
          report_mismatch(v_name[i], "commit_mask", 64'(v_mask[i]), 64'(commit_mask));
        end
        if (commit_data !== lanes) begin
          report_mismatch(v_name[i], "commit_data", lanes, commit_data);
        end
      end
    end
    finish_test(v_name[i], errs_before);
  endtask

  // alternating random stores and loads issued back to back
  task automatic run_random();
    int unsigned      r;
    mem_pkg::mem_op_e op;
    logic [2:0]       off;
    logic [63:0]      base;
    logic [63:0]      addr;
    logic [63:0]      wdata;
    logic [63:0]      pc;
    int               errs_before;
    errs_before = errors;
    base = 64'h200;
    rand_phase = 1'b1;
    @(posedge clk);
    for (int k = 0; k < rand_items; k++) begin
      r = $urandom;
      pc = 64'h9000_0000 + 64'(k * 4);
      wdata = {$urandom, $urandom};
      if (k % 2 == 0) begin
        case (r[1:0])
          2'd0:    op = mem_pkg::op_sb;
          2'd1:    op = mem_pkg::op_sh;
          2'd2:    op = mem_pkg::op_sw;
          default: op = mem_pkg::op_sd;
        endcase
        base = 64'h200 + 64'(r[8:5]) * 64'd8;
      end else begin
        case (r[2:0])
          3'd0:    op = mem_pkg::op_lb;
          3'd1:    op = mem_pkg::op_lh;
          3'd2:    op = mem_pkg::op_lw;
          3'd3:    op = mem_pkg::op_ld;
          3'd4:    op = mem_pkg::op_lbu;
          3'd5:    op = mem_pkg::op_lhu;
          default: op = mem_pkg::op_lwu;
        endcase
      end
      off = r[11:9] & ~3'(op_bytes(op) - 1);
      addr = base + 64'(off);
      exp_pc_q.push_back(pc);
      if (is_store_op(op)) begin
        exp_val_q.push_back(lanes_of(op, addr, wdata));
        model_store(op, addr, wdata);
        drive_item(pc, op, addr, wdata, 64'h0, 5'd0, mem_pkg::wb_ex);
      end else begin
        exp_val_q.push_back(model_load(op, addr));
        drive_item(pc, op, addr, wdata, 64'h0, 5'd3, mem_pkg::wb_load);
      end
      wait_accept();
    end
    ex_valid <= 1'b0;
    while (obs_pc_q.size() < rand_items) begin
      @(negedge clk);
    end
    repeat (3) @(negedge clk);
    rand_phase = 1'b0;
    if (obs_pc_q.size() != rand_items) begin
      report_problem("rand_b2b", "more commits arrived than items were issued");
    end
    for (int k = 0; k < rand_items; k++) begin
      if (obs_pc_q[k] !== exp_pc_q[k]) begin
        report_mismatch("rand_b2b", "commit_pc", exp_pc_q[k], obs_pc_q[k]);
      end
      if (obs_val_q[k] !== exp_val_q[k]) begin
        report_mismatch("rand_b2b", "commit value", exp_val_q[k], obs_val_q[k]);
      end
    end
    finish_test("rand_b2b", errs_before);
  endtask

  initial begin
    int errs_before;
    void'($urandom(32'h4a0c_90b4));
    rst         <= 1'b1;
    ex_valid    <= 1'b0;
    ex_pc       <= '0;
    ex_op       <= mem_pkg::op_none;
    ex_addr     <= '0;
    ex_wdata    <= '0;
    ex_csr_data <= '0;
    ex_rd       <= '0;
    ex_rd_wen   <= 1'b0;
    ex_wb_sel   <= mem_pkg::wb_ex;
    for (int a = 0; a < 2048; a++) begin
      model_mem[a] = 8'h00;
    end
    load_vectors();
    limit = (v_name.size() + rand_items) * (ram_wait + 6) + reset_cyc;

    repeat (reset_cyc) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    errs_before = errors;
    if (rf_wen !== 1'b0 || commit_valid !== 1'b0 || fwd_wen !== 1'b0) begin
      report_problem("reset_state", "an output valid was high after reset");
    end
    if (ex_allowin !== 1'b1) begin
      report_problem("reset_state", "ex_allowin was low after reset");
    end
    finish_test("reset_state", errs_before);

    for (int i = 0; i < v_name.size(); i++) begin
      run_vector(i);
    end
    run_random();

    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/mem_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_top #(
  parameter int ram_addr_bits = 8,
  parameter int ram_wait      = 2
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     ex_valid,
  input  logic [mem_pkg::xlen-1:0] ex_pc,
  input  mem_pkg::mem_op_e         ex_op,
  input  logic [mem_pkg::xlen-1:0] ex_addr,
  input  logic [mem_pkg::xlen-1:0] ex_wdata,
  input  logic [mem_pkg::xlen-1:0] ex_csr_data,
  input  logic [4:0]               ex_rd,
  input  logic                     ex_rd_wen,
  input  mem_pkg::wb_sel_e         ex_wb_sel,
  output logic                     ex_allowin,
  output logic [4:0]               fwd_rd,
  output logic                     fwd_wen,
  output logic [mem_pkg::xlen-1:0] fwd_data,
  output mem_pkg::wb_sel_e         fwd_wb_sel,
  output logic                     rf_wen,
  output logic [4:0]               rf_waddr,
  output logic [mem_pkg::xlen-1:0] rf_wdata,
  output logic                     commit_valid,
  output logic [mem_pkg::xlen-1:0] commit_pc,
  output logic                     commit_load,
  output logic                     commit_store,
  output logic [mem_pkg::xlen-1:0] commit_addr,
  output logic [mem_pkg::xlen-1:0] commit_data,
  output logic [7:0]               commit_mask
);

  // memory port
  logic                     req_valid;
  logic                     req_ready;
  logic                     req_write;
  logic [mem_pkg::xlen-1:0] req_addr;
  logic [mem_pkg::xlen-1:0] req_wdata;
  mem_pkg::mem_size_e       req_size;
  logic [mem_pkg::xlen-1:0] rdata;

  // stage to writeback
  logic                     wb_valid;
  logic [mem_pkg::xlen-1:0] wb_pc;
  logic [4:0]               wb_rd;
  logic                     wb_rd_wen;
  mem_pkg::wb_sel_e         wb_sel;
  logic [mem_pkg::xlen-1:0] wb_ex_data;
  logic [mem_pkg::xlen-1:0] wb_load_data;
  logic [mem_pkg::xlen-1:0] wb_csr_data;
  mem_pkg::mem_op_e         wb_op;
  logic [mem_pkg::xlen-1:0] wb_addr;
  logic [mem_pkg::xlen-1:0] st_lane_data;
  logic [7:0]               st_mask;

  mem_stage mem_stage_i (.*);

  data_ram #(
    .ram_addr_bits (ram_addr_bits),
    .ram_wait      (ram_wait)
  ) data_ram_i (.*);

  wb_stage wb_stage_i (.*);

endmodule

`default_nettype wire

//--- rtl/wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

module wb_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wb_valid,
  input  logic [mem_pkg::xlen-1:0] wb_pc,
  input  logic [4:0]               wb_rd,
  input  logic                     wb_rd_wen,
  input  mem_pkg::wb_sel_e         wb_sel,
  input  logic [mem_pkg::xlen-1:0] wb_ex_data,
  input  logic [mem_pkg::xlen-1:0] wb_load_data,
  input  logic [mem_pkg::xlen-1:0] wb_csr_data,
  input  mem_pkg::mem_op_e         wb_op,
  input  logic [mem_pkg::xlen-1:0] wb_addr,
  input  logic [mem_pkg::xlen-1:0] st_lane_data,
  input  logic [7:0]               st_mask,
  output logic                     rf_wen,
  output logic [4:0]               rf_waddr,
  output logic [mem_pkg::xlen-1:0] rf_wdata,
  output logic                     commit_valid,
  output logic [mem_pkg::xlen-1:0] commit_pc,
  output logic                     commit_load,
  output logic                     commit_store,
  output logic [mem_pkg::xlen-1:0] commit_addr,
  output logic [mem_pkg::xlen-1:0] commit_data,
  output logic [7:0]               commit_mask
);

  logic             valid_q;
  logic             rd_wen_q;
  mem_pkg::mem_op_e op_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= wb_valid;
    end
  end

  // result chosen on capture
  always_ff @(posedge clk) begin
    if (wb_valid) begin
      rd_wen_q    <= wb_rd_wen;
      rf_waddr    <= wb_rd;
      op_q        <= wb_op;
      commit_pc   <= wb_pc;
      commit_addr <= {wb_addr[mem_pkg::xlen-1:3], 3'b000};
      commit_data <= st_lane_data;
      commit_mask <= st_mask;
      case (wb_sel)
        mem_pkg::wb_load: rf_wdata <= wb_load_data;
        mem_pkg::wb_csr:  rf_wdata <= wb_csr_data;
        default:          rf_wdata <= wb_ex_data;
      endcase
    end
  end

  // x0 is never written
  assign rf_wen       = valid_q && rd_wen_q && rf_waddr != 5'd0;
  assign commit_valid = valid_q && op_q != mem_pkg::op_none;
  assign commit_store = commit_valid && op_q >= mem_pkg::op_sb;
  assign commit_load  = commit_valid && op_q < mem_pkg::op_sb;

endmodule

`default_nettype wire

//--- rtl/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram #(
  parameter int ram_addr_bits = 8,
  parameter int ram_wait      = 2
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req_valid,
  input  logic                     req_write,
  input  logic [mem_pkg::xlen-1:0] req_addr,
  input  logic [mem_pkg::xlen-1:0] req_wdata,
  input  mem_pkg::mem_size_e       req_size,
  output logic                     req_ready,
  output logic [mem_pkg::xlen-1:0] rdata
);

  localparam int depth    = 2 ** ram_addr_bits;
  localparam int cnt_bits = (ram_wait > 0) ? $clog2(ram_wait + 1) : 1;

  logic [mem_pkg::xlen-1:0] mem [depth];
  logic [cnt_bits-1:0]      wait_cnt;
  logic [ram_addr_bits-1:0] index;
  logic [2:0]               offset;
  logic [7:0]               byte_en;
  logic [mem_pkg::xlen-1:0] wdata_sh;

  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = '0;
    end
  end

  // doubleword index above the byte offset
  assign index  = req_addr[ram_addr_bits+2:3];
  assign offset = req_addr[2:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt <= '0;
    end else if (req_ready) begin
      wait_cnt <= '0;
    end else if (req_valid) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  assign req_ready = req_valid && wait_cnt == cnt_bits'(ram_wait);

  assign byte_en  = mem_pkg::size_pattern(req_size) << offset;
  assign wdata_sh = req_wdata << {offset, 3'b000};

  always @(posedge clk) begin
    if (req_ready && req_write) begin
      for (int i = 0; i < 8; i++) begin
        if (byte_en[i]) begin
          mem[index][i*8 +: 8] <= wdata_sh[i*8 +: 8];
        end
      end
    end
  end

  assign rdata = mem[index] >> {offset, 3'b000};

  // a request is never withdrawn
  assert property (@(posedge clk) disable iff (rst)
    req_valid && !req_ready |=> req_valid);

endmodule

`default_nettype wire

//--- rtl/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     ex_valid,
  input  logic [mem_pkg::xlen-1:0] ex_pc,
  input  mem_pkg::mem_op_e         ex_op,
  input  logic [mem_pkg::xlen-1:0] ex_addr,
  input  logic [mem_pkg::xlen-1:0] ex_wdata,
  input  logic [mem_pkg::xlen-1:0] ex_csr_data,
  input  logic [4:0]               ex_rd,
  input  logic                     ex_rd_wen,
  input  mem_pkg::wb_sel_e         ex_wb_sel,
  output logic                     ex_allowin,
  output logic                     req_valid,
  output logic                     req_write,
  output logic [mem_pkg::xlen-1:0] req_addr,
  output logic [mem_pkg::xlen-1:0] req_wdata,
  output mem_pkg::mem_size_e       req_size,
  input  logic                     req_ready,
  input  logic [mem_pkg::xlen-1:0] rdata,
  output logic                     wb_valid,
  output logic [mem_pkg::xlen-1:0] wb_pc,
  output logic [4:0]               wb_rd,
  output logic                     wb_rd_wen,
  output mem_pkg::wb_sel_e         wb_sel,
  output logic [mem_pkg::xlen-1:0] wb_ex_data,
  output logic [mem_pkg::xlen-1:0] wb_load_data,
  output logic [mem_pkg::xlen-1:0] wb_csr_data,
  output mem_pkg::mem_op_e         wb_op,
  output logic [mem_pkg::xlen-1:0] wb_addr,
  output logic [mem_pkg::xlen-1:0] st_lane_data,
  output logic [7:0]               st_mask,
  output logic [4:0]               fwd_rd,
  output logic                     fwd_wen,
  output logic [mem_pkg::xlen-1:0] fwd_data,
  output mem_pkg::wb_sel_e         fwd_wb_sel
);

  logic                     valid_q;
  logic [mem_pkg::xlen-1:0] pc_q;
  mem_pkg::mem_op_e         op_q;
  logic [mem_pkg::xlen-1:0] addr_q;
  logic [mem_pkg::xlen-1:0] wdata_q;
  logic [mem_pkg::xlen-1:0] csr_q;
  logic [4:0]               rd_q;
  logic                     rd_wen_q;
  mem_pkg::wb_sel_e         wb_sel_q;
  logic [mem_pkg::xlen-1:0] load_q;
  logic [mem_pkg::xlen-1:0] ext_data;
  mem_pkg::mem_state_e      state_q;
  mem_pkg::mem_state_e      state_d;
  logic                     is_mem;
  logic                     ex_is_mem;
  logic                     ready_go;
  logic                     accept;
  logic                     handshake;

  assign is_mem    = op_q != mem_pkg::op_none;
  assign ex_is_mem = ex_op != mem_pkg::op_none;
  // memory items leave only from st_retn
  assign ready_go   = !is_mem || state_q == mem_pkg::st_retn;
  assign ex_allowin = !valid_q || ready_go;
  assign accept     = ex_valid && ex_allowin;
  assign handshake  = req_valid && req_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      state_q <= mem_pkg::st_idle;
    end else begin
      if (ex_allowin) begin
        valid_q <= ex_valid;
      end
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pc_q     <= ex_pc;
      op_q     <= ex_op;
      addr_q   <= ex_addr;
      wdata_q  <= ex_wdata;
      csr_q    <= ex_csr_data;
      rd_q     <= ex_rd;
      rd_wen_q <= ex_rd_wen;
      wb_sel_q <= ex_wb_sel;
    end
    if (handshake) begin
      load_q <= ext_data;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      mem_pkg::st_idle: begin
        if (accept && ex_is_mem) begin
          state_d = mem_pkg::st_addr;
        end
      end
      mem_pkg::st_addr: begin
        if (handshake) begin
          state_d = mem_pkg::st_retn;
        end
      end
      mem_pkg::st_retn: begin
        // back to back access skips st_idle
        if (accept && ex_is_mem) begin
          state_d = mem_pkg::st_addr;
        end else begin
          state_d = mem_pkg::st_idle;
        end
      end
      default: state_d = mem_pkg::st_idle;
    endcase
  end

  store_format store_format_i (
    .op        (op_q),
    .addr      (addr_q[2:0]),
    .wdata     (wdata_q),
    .size      (req_size),
    .req_wdata (req_wdata),
    .lane_data (st_lane_data),
    .mask      (st_mask)
  );

  load_extend load_extend_i (
    .op    (op_q),
    .rdata (rdata),
    .data  (ext_data)
  );

  assign req_valid = state_q == mem_pkg::st_addr;
  assign req_write = op_q >= mem_pkg::op_sb;
  assign req_addr  = addr_q;

  assign wb_valid     = valid_q && ready_go;
  assign wb_pc        = pc_q;
  assign wb_rd        = rd_q;
  assign wb_rd_wen    = rd_wen_q;
  assign wb_sel       = wb_sel_q;
  assign wb_ex_data   = addr_q;
  assign wb_load_data = load_q;
  assign wb_csr_data  = csr_q;
  assign wb_op        = op_q;
  assign wb_addr      = addr_q;

  // forwarding view toward decode
  assign fwd_rd     = valid_q ? rd_q : 5'd0;
  assign fwd_wen    = valid_q && rd_wen_q;
  assign fwd_data   = valid_q ? addr_q : '0;
  assign fwd_wb_sel = valid_q ? wb_sel_q : mem_pkg::wb_ex;

  // request holds steady until the memory takes it
  assert property (@(posedge clk) disable iff (rst)
    req_valid && !req_ready |=> req_valid && $stable(req_addr) && $stable(req_wdata)
      && $stable(req_write) && $stable(req_size));

  assert property (@(posedge clk) disable iff (rst)
    !(wb_valid && state_q == mem_pkg::st_addr));

endmodule

`default_nettype wire

//--- rtl/load_extend.sv
`timescale 1ns/1ns
`default_nettype none

module load_extend (
  input  mem_pkg::mem_op_e         op,
  input  logic [mem_pkg::xlen-1:0] rdata,
  output logic [mem_pkg::xlen-1:0] data
);

  // rdata arrives right-justified
  always_comb begin
    case (op)
      mem_pkg::op_lb:  data = {{56{rdata[7]}}, rdata[7:0]};
      mem_pkg::op_lh:  data = {{48{rdata[15]}}, rdata[15:0]};
      mem_pkg::op_lw:  data = {{32{rdata[31]}}, rdata[31:0]};
      mem_pkg::op_lbu: data = {56'd0, rdata[7:0]};
      mem_pkg::op_lhu: data = {48'd0, rdata[15:0]};
      mem_pkg::op_lwu: data = {32'd0, rdata[31:0]};
      // ld passes through
      default:         data = rdata;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/store_format.sv
`timescale 1ns/1ns
`default_nettype none

module store_format (
  input  mem_pkg::mem_op_e         op,
  input  logic [2:0]               addr,
  input  logic [mem_pkg::xlen-1:0] wdata,
  output mem_pkg::mem_size_e       size,
  output logic [mem_pkg::xlen-1:0] req_wdata,
  output logic [mem_pkg::xlen-1:0] lane_data,
  output logic [7:0]               mask
);

  logic [7:0]               size_bits;
  logic [mem_pkg::xlen-1:0] size_mask;
  logic [mem_pkg::xlen-1:0] lane_mask;
  logic [mem_pkg::xlen-1:0] repl;
  logic                     is_store;

  always_comb begin
    case (op)
      mem_pkg::op_lb, mem_pkg::op_lbu, mem_pkg::op_sb: size = mem_pkg::size_b;
      mem_pkg::op_lh, mem_pkg::op_lhu, mem_pkg::op_sh: size = mem_pkg::size_h;
      mem_pkg::op_lw, mem_pkg::op_lwu, mem_pkg::op_sw: size = mem_pkg::size_w;
      default: size = mem_pkg::size_d;
    endcase
  end

  assign size_bits = mem_pkg::size_pattern(size);
  assign mask      = size_bits << addr;

  // byte enables widened to bit masks
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      size_mask[i*8 +: 8] = {8{size_bits[i]}};
      lane_mask[i*8 +: 8] = {8{mask[i]}};
    end
  end

  assign req_wdata = wdata & size_mask;

  always_comb begin
    case (size)
      mem_pkg::size_b: repl = {8{req_wdata[7:0]}};
      mem_pkg::size_h: repl = {4{req_wdata[15:0]}};
      mem_pkg::size_w: repl = {2{req_wdata[31:0]}};
      default:         repl = req_wdata;
    endcase
  end

  assign is_store  = op >= mem_pkg::op_sb;
  assign lane_data = is_store ? (repl & lane_mask) : '0;

endmodule

`default_nettype wire

//--- rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // RV64 only
  localparam int xlen = 64;

  typedef enum logic [3:0] {
    op_none = 4'd0,
    op_lb   = 4'd1,
    op_lh   = 4'd2,
    op_lw   = 4'd3,
    op_ld   = 4'd4,
    op_lbu  = 4'd5,
    op_lhu  = 4'd6,
    op_lwu  = 4'd7,
    op_sb   = 4'd8,
    op_sh   = 4'd9,
    op_sw   = 4'd10,
    op_sd   = 4'd11
  } mem_op_e;

  typedef enum logic [1:0] {
    size_b = 2'd0,
    size_h = 2'd1,
    size_w = 2'd2,
    size_d = 2'd3
  } mem_size_e;

  // wb_ex also carries the address field
  typedef enum logic [1:0] {
    wb_ex   = 2'd0,
    wb_load = 2'd1,
    wb_csr  = 2'd2
  } wb_sel_e;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_addr = 2'd1,
    st_retn = 2'd2
  } mem_state_e;

  // byte pattern of an access at offset zero
  function automatic logic [7:0] size_pattern(mem_size_e size);
    case (size)
      size_b:  return 8'b0000_0001;
      size_h:  return 8'b0000_0011;
      size_w:  return 8'b0000_1111;
      default: return 8'b1111_1111;
    endcase
  endfunction

endpackage

`default_nettype wire
